// ==== hdl/selen_wb_pkg.sv ====
// Shared types and default sizes for the memory system; DEPTH must be a power of two, DW a multiple of 8.
package selen_wb_pkg;

  // ======================================================================
  // Bus ownership
  // ======================================================================

  // Owner of the shared slave bus.
  // One bit, so the arbiter can hold it in a single flop.
  typedef enum logic [0:0] {
    MST_HOST = 1'b0, // External host port.
    MST_DMA  = 1'b1  // Block-copy engine.
  } wb_master_e;

  // ======================================================================
  // Copy engine FSM
  // ======================================================================

  // Block-copy engine states.
  typedef enum logic [1:0] {
    IDLE   = 2'd0, // Waiting for start.
    READ   = 2'd1, // Fetching a source word.
    WRITE  = 2'd2, // Storing it at the destination.
    FINISH = 2'd3  // One-cycle done pulse.
  } blk_state_e;

  // ======================================================================
  // Default sizes
  // ======================================================================

  // Top-level defaults, passed down as module parameters.
  localparam int WB_AW_DEF     = 32;  // Byte address width.
  localparam int WB_DW_DEF     = 32;  // Data width.
  localparam int RAM_DEPTH_DEF = 256; // Words, so 1 kB at 32 bits.

endpackage

// ==== hdl/sram_sp_be.sv ====
// Single-port RAM with byte write enables; read data is registered, no reset on contents or output.
`timescale 1ns/1ps

module sram_sp_be #(
  parameter int DW    = 32,  // Word width, multiple of 8.
  parameter int DEPTH = 256  // Words, power of two.
) (
  input  logic                     clk_i,
  input  logic                     en_i,   // Access this edge.
  input  logic                     we_i,   // Write when high, else read.
  input  logic [DW/8-1:0]          wbe_i,  // One enable per byte lane.
  input  logic [$clog2(DEPTH)-1:0] adr_i,  // Word index.
  input  logic [DW-1:0]            dat_i,
  output logic [DW-1:0]            dat_o   // Registered read word.
);

  logic [DW-1:0] mem [DEPTH]; // Storage array.

  // Write selected lanes, or capture the read word.
  // Output register keeps its value while idle.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < DW/8; b++) begin
          if (wbe_i[b]) begin
            mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8]; // Lane b.
          end
        end
      end else begin
        dat_o <= mem[adr_i]; // Valid next cycle.
      end
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================

  // A write with no lane enabled means the bus master sent sel = 0.
  a_wbe_nonzero: assert property (
    @(posedge clk_i) (en_i && we_i) |-> (wbe_i != '0)
  ) else $error("sram_sp_be: write with all byte enables low");

endmodule

// ==== hdl/wb_ram.sv ====
// Wishbone classic slave, single accesses only; addresses past DEPTH words give err and no write.
`timescale 1ns/1ps

module wb_ram #(
  parameter int AW    = 32,  // Byte address width.
  parameter int DW    = 32,  // Data width.
  parameter int DEPTH = 256  // RAM words.
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  logic [DW-1:0]   wb_dat_i,
  input  logic [AW-1:0]   wb_adr_i,
  input  logic [DW/8-1:0] wb_sel_i,
  input  logic            wb_we_i,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  output logic [DW-1:0]   wb_dat_o,
  output logic            wb_ack_o,
  output logic            wb_err_o
);

  localparam int OB = $clog2(DW/8);  // Byte offset bits.
  localparam int IW = $clog2(DEPTH); // Word index bits.

  logic          ack_q;       // Registered ack.
  logic          err_q;       // Registered err.
  logic          req_new;     // Request not yet answered.
  logic          out_of_rng;  // Address bits above the RAM set.
  logic          mem_en;
  logic [IW-1:0] mem_adr;

  // A request seen while its response is out is the same request.
  assign req_new    = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;
  assign out_of_rng = (wb_adr_i >> (OB + IW)) != '0; // Any high bit.
  assign mem_en     = req_new & ~out_of_rng;         // Blocks bad writes.
  assign mem_adr    = wb_adr_i[OB +: IW];            // Byte to word.

  sram_sp_be #(
    .DW    (DW),
    .DEPTH (DEPTH)
  ) u_ram (
    .clk_i (wb_clk_i),
    .en_i  (mem_en),
    .we_i  (wb_we_i),
    .wbe_i (wb_sel_i),
    .adr_i (mem_adr),
    .dat_i (wb_dat_i),
    .dat_o (wb_dat_o)  // Lines up with ack.
  );

  // One-cycle response, never back to back.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_new & ~out_of_rng;
      err_q <= req_new &  out_of_rng;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

  // ======================================================================
  // Checks
  // ======================================================================

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o)
  ) else $error("wb_ram: ack and err together");

  // Every response answers a strobe of the cycle before.
  a_resp_has_req: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("wb_ram: response without request");

endmodule

// ==== hdl/wb_arbiter.sv ====
// Two-master Wishbone classic arbiter; owner kept while its cyc is high, round-robin on ties.
`timescale 1ns/1ps

module wb_arbiter
  import selen_wb_pkg::*;
#(
  parameter int AW = 32,  // Byte address width.
  parameter int DW = 32   // Data width.
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  // Host master.
  input  logic            h_cyc_i,
  input  logic            h_stb_i,
  input  logic            h_we_i,
  input  logic [AW-1:0]   h_adr_i,
  input  logic [DW/8-1:0] h_sel_i,
  input  logic [DW-1:0]   h_dat_i,
  output logic [DW-1:0]   h_dat_o,
  output logic            h_ack_o,
  output logic            h_err_o,
  // Copy engine master.
  input  logic            d_cyc_i,
  input  logic            d_stb_i,
  input  logic            d_we_i,
  input  logic [AW-1:0]   d_adr_i,
  input  logic [DW/8-1:0] d_sel_i,
  input  logic [DW-1:0]   d_dat_i,
  output logic [DW-1:0]   d_dat_o,
  output logic            d_ack_o,
  output logic            d_err_o,
  // Slave bus.
  output logic            s_cyc_o,
  output logic            s_stb_o,
  output logic            s_we_o,
  output logic [AW-1:0]   s_adr_o,
  output logic [DW/8-1:0] s_sel_o,
  output logic [DW-1:0]   s_dat_o,
  input  logic [DW-1:0]   s_dat_i,
  input  logic            s_ack_i,
  input  logic            s_err_i,
  output wb_master_e      gnt_o    // Current owner.
);

  wb_master_e gnt_q;   // Owner of the last cycle.
  wb_master_e gnt_c;   // Owner this cycle.
  wb_master_e last_q;  // Last master to use the bus, loses ties.
  logic       busy_q;  // Owner held cyc last cycle.
  logic       own_cyc; // Owner's cyc now.
  logic       is_dma;

  // ======================================================================
  // Grant
  // ======================================================================

  // Decide only on an idle bus, so no extra cycle for the winner.
  always_comb begin
    if (busy_q) begin
      gnt_c = gnt_q;                       // Locked to the owner.
    end else if (h_cyc_i && d_cyc_i) begin
      gnt_c = (last_q == MST_HOST) ? MST_DMA : MST_HOST; // Round-robin.
    end else if (d_cyc_i) begin
      gnt_c = MST_DMA;
    end else if (h_cyc_i) begin
      gnt_c = MST_HOST;
    end else begin
      gnt_c = gnt_q;                       // Park.
    end
  end

  assign is_dma  = (gnt_c == MST_DMA);
  assign own_cyc = is_dma ? d_cyc_i : h_cyc_i;
  assign gnt_o   = gnt_c;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      busy_q <= 1'b0;
      gnt_q  <= MST_HOST;
      last_q <= MST_DMA;  // Host wins the first tie.
    end else begin
      busy_q <= own_cyc;  // Released once cyc drops.
      gnt_q  <= gnt_c;
      if (own_cyc) last_q <= gnt_c;
    end
  end

  // ======================================================================
  // Request mux and response routing
  // ======================================================================

  assign s_cyc_o = own_cyc;
  assign s_stb_o = is_dma ? d_stb_i : h_stb_i;
  assign s_we_o  = is_dma ? d_we_i  : h_we_i;
  assign s_adr_o = is_dma ? d_adr_i : h_adr_i;
  assign s_sel_o = is_dma ? d_sel_i : h_sel_i;
  assign s_dat_o = is_dma ? d_dat_i : h_dat_i;

  // The other master sees nothing.
  assign h_ack_o = s_ack_i & ~is_dma;
  assign h_err_o = s_err_i & ~is_dma;
  assign h_dat_o = is_dma ? '0 : s_dat_i;
  assign d_ack_o = s_ack_i &  is_dma;
  assign d_err_o = s_err_i &  is_dma;
  assign d_dat_o = is_dma ? s_dat_i : '0;

  // Ownership cannot move mid-cycle.
  a_gnt_held: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) own_cyc |=> (gnt_c == $past(gnt_c))
  ) else $error("wb_arbiter: grant changed while owner held cyc");

endmodule

// ==== hdl/wb_blk_copy.sv ====
// Word-by-word copy master; one read then one write per word, each its own bus cycle; no overlap check.
`timescale 1ns/1ps

module wb_blk_copy
  import selen_wb_pkg::*;
#(
  parameter int AW = 32,  // Byte address width.
  parameter int DW = 32   // Data width.
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  logic            start_i,  // One-cycle pulse.
  input  logic [AW-1:0]   src_i,    // Source byte address.
  input  logic [AW-1:0]   dst_i,    // Destination byte address.
  input  logic [15:0]     len_i,    // Words to copy.
  output logic            busy_o,
  output logic            done_o,
  output logic            err_o,    // Abort, valid with done.
  // Bus master.
  output logic            m_cyc_o,
  output logic            m_stb_o,
  output logic            m_we_o,
  output logic [AW-1:0]   m_adr_o,
  output logic [DW/8-1:0] m_sel_o,
  output logic [DW-1:0]   m_dat_o,
  input  logic [DW-1:0]   m_dat_i,
  input  logic            m_ack_i,
  input  logic            m_err_i
);

  localparam logic [AW-1:0] STEP = AW'(DW/8); // Bytes per word.

  blk_state_e    state_q;
  logic          gap_q;    // Idle cycle after each response.
  logic          err_q;    // Sticky abort flag.
  logic          req;      // Bus request this cycle.
  logic [AW-1:0] src_q;
  logic [AW-1:0] dst_q;
  logic [15:0]   cnt_q;    // Words left.
  logic [DW-1:0] buf_q;    // Word in flight.

  // ======================================================================
  // FSM
  // ======================================================================

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q <= IDLE;
      gap_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      gap_q <= req & (m_ack_i | m_err_i); // Drop cyc for one cycle.
      case (state_q)
        IDLE: begin
          if (start_i) begin
            err_q   <= 1'b0;
            state_q <= (len_i == 16'd0) ? FINISH : READ;
          end
        end
        READ, WRITE: begin
          if (req && m_err_i) begin
            err_q   <= 1'b1;                  // Abort the copy.
            state_q <= FINISH;
          end else if (req && m_ack_i) begin
            if (state_q == READ) state_q <= WRITE;
            else state_q <= (cnt_q == 16'd1) ? FINISH : READ;
          end
        end
        default: state_q <= IDLE;             // FINISH lasts a cycle.
      endcase
    end
  end

  // Addresses, count and data buffer.
  always_ff @(posedge wb_clk_i) begin
    if (state_q == IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      cnt_q <= len_i;
    end else if (req && m_ack_i) begin
      if (state_q == READ) begin
        buf_q <= m_dat_i;                     // Latch read word.
        src_q <= src_q + STEP;
      end else begin
        dst_q <= dst_q + STEP;
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // ======================================================================
  // Outputs
  // ======================================================================

  assign req     = ((state_q == READ) || (state_q == WRITE)) & ~gap_q;
  assign m_cyc_o = req;
  assign m_stb_o = req;
  assign m_we_o  = (state_q == WRITE);
  assign m_adr_o = (state_q == WRITE) ? dst_q : src_q;
  assign m_sel_o = '1;                        // Whole words only.
  assign m_dat_o = buf_q;

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == FINISH);
  assign err_o  = (state_q == FINISH) & err_q;

  a_stb_in_xfer: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      m_stb_o |-> (state_q inside {READ, WRITE})
  ) else $error("wb_blk_copy: stb outside a transfer state");

endmodule

// ==== hdl/wb_mem_sys.sv ====
// Shared RAM system top; host port and copy engine share one slave through the arbiter, classic cycles only.
`timescale 1ns/1ps

module wb_mem_sys
  import selen_wb_pkg::*;
#(
  parameter int AW    = WB_AW_DEF,     // Byte address width.
  parameter int DW    = WB_DW_DEF,     // Data width.
  parameter int DEPTH = RAM_DEPTH_DEF  // RAM words.
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  // Host bus.
  input  logic            wb_h_cyc_i,
  input  logic            wb_h_stb_i,
  input  logic            wb_h_we_i,
  input  logic [AW-1:0]   wb_h_adr_i,
  input  logic [DW/8-1:0] wb_h_sel_i,
  input  logic [DW-1:0]   wb_h_dat_i,
  output logic [DW-1:0]   wb_h_dat_o,
  output logic            wb_h_ack_o,
  output logic            wb_h_err_o,
  // Copy engine control.
  input  logic            dma_start_i,
  input  logic [AW-1:0]   dma_src_i,
  input  logic [AW-1:0]   dma_dst_i,
  input  logic [15:0]     dma_len_i,
  output logic            dma_busy_o,
  output logic            dma_done_o,
  output logic            dma_err_o,
  output wb_master_e      gnt_o     // Bus owner, for observation.
);

  // ======================================================================
  // Internal buses
  // ======================================================================

  // Copy engine to arbiter.
  logic            dma_cyc, dma_stb, dma_we;
  logic [AW-1:0]   dma_adr;
  logic [DW/8-1:0] dma_sel;
  logic [DW-1:0]   dma_dat_m2s, dma_dat_s2m;
  logic            dma_ack, dma_err;

  // Arbiter to RAM.
  logic            ram_cyc, ram_stb, ram_we;
  logic [AW-1:0]   ram_adr;
  logic [DW/8-1:0] ram_sel;
  logic [DW-1:0]   ram_dat_m2s, ram_dat_s2m;
  logic            ram_ack, ram_err;

  wb_blk_copy #(.AW(AW), .DW(DW)) u_copy (
    .wb_clk_i (wb_clk_i),   .wb_rst_i (wb_rst_i),
    .start_i  (dma_start_i), .src_i   (dma_src_i),  .dst_i (dma_dst_i),
    .len_i    (dma_len_i),   .busy_o  (dma_busy_o), .done_o (dma_done_o),
    .err_o    (dma_err_o),
    .m_cyc_o  (dma_cyc),     .m_stb_o (dma_stb),    .m_we_o (dma_we),
    .m_adr_o  (dma_adr),     .m_sel_o (dma_sel),    .m_dat_o (dma_dat_m2s),
    .m_dat_i  (dma_dat_s2m), .m_ack_i (dma_ack),    .m_err_i (dma_err)
  );

  wb_arbiter #(.AW(AW), .DW(DW)) u_arb (
    .wb_clk_i (wb_clk_i),    .wb_rst_i (wb_rst_i),
    .h_cyc_i  (wb_h_cyc_i),  .h_stb_i (wb_h_stb_i), .h_we_i  (wb_h_we_i),
    .h_adr_i  (wb_h_adr_i),  .h_sel_i (wb_h_sel_i), .h_dat_i (wb_h_dat_i),
    .h_dat_o  (wb_h_dat_o),  .h_ack_o (wb_h_ack_o), .h_err_o (wb_h_err_o),
    .d_cyc_i  (dma_cyc),     .d_stb_i (dma_stb),    .d_we_i  (dma_we),
    .d_adr_i  (dma_adr),     .d_sel_i (dma_sel),    .d_dat_i (dma_dat_m2s),
    .d_dat_o  (dma_dat_s2m), .d_ack_o (dma_ack),    .d_err_o (dma_err),
    .s_cyc_o  (ram_cyc),     .s_stb_o (ram_stb),    .s_we_o  (ram_we),
    .s_adr_o  (ram_adr),     .s_sel_o (ram_sel),    .s_dat_o (ram_dat_m2s),
    .s_dat_i  (ram_dat_s2m), .s_ack_i (ram_ack),    .s_err_i (ram_err),
    .gnt_o    (gnt_o)
  );

  wb_ram #(.AW(AW), .DW(DW), .DEPTH(DEPTH)) u_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_dat_i (ram_dat_m2s),
    .wb_adr_i (ram_adr),
    .wb_sel_i (ram_sel),
    .wb_we_i  (ram_we),
    .wb_cyc_i (ram_cyc),
    .wb_stb_i (ram_stb),
    .wb_dat_o (ram_dat_s2m),
    .wb_ack_o (ram_ack),
    .wb_err_o (ram_err)
  );

endmodule

// ==== dv/tb_wb_mem_sys.sv ====
// Directed testbench for the shared RAM system at the package default sizes; fixed-seed host data.
`timescale 1ns/1ps

module tb_wb_mem_sys
  import selen_wb_pkg::*;
();

  // ======================================================================
  // Sizes, regions and run length
  // ======================================================================

  localparam int AW    = WB_AW_DEF;
  localparam int DW    = WB_DW_DEF;
  localparam int DEPTH = RAM_DEPTH_DEF;
  localparam int NB    = DW / 8;         // Byte lanes.
  localparam int OB    = $clog2(NB);     // Byte offset bits.
  localparam int IW    = $clog2(DEPTH);  // Word index bits.

  localparam int N_RW  = 16;   // Random words in the write/read sweep.
  localparam int N_CP  = 32;   // Words in the plain copy.
  localparam int N_CP2 = 16;   // Words in the copy under host traffic.
  localparam int N_BG  = 8;    // Host write/read pairs during that copy.
  localparam int SRC1  = 64;   // Word indices of the regions.
  localparam int SRC2  = 96;
  localparam int DST1  = 128;
  localparam int DST2  = 160;
  localparam int BG    = 192;  // Host region, clear of both copies.
  localparam int ALIAS = 40;
  localparam int IDLE_LAT = 2; // Negedges from request to ack on an idle bus.

  // Host accesses of all tests; 4 cycles each, 8 per copied word, then margin.
  localparam int HOST_OPS    = 3 * N_RW + 4 + (N_CP + N_CP2) + N_CP + 2 * N_BG + N_CP2;
  localparam int TIMEOUT_CYC = 4 * HOST_OPS + 8 * (N_CP + N_CP2) + 100;

  logic            wb_clk_i;
  logic            wb_rst_i;
  logic            wb_h_cyc_i;
  logic            wb_h_stb_i;
  logic            wb_h_we_i;
  logic [AW-1:0]   wb_h_adr_i;
  logic [NB-1:0]   wb_h_sel_i;
  logic [DW-1:0]   wb_h_dat_i;
  logic [DW-1:0]   wb_h_dat_o;
  logic            wb_h_ack_o;
  logic            wb_h_err_o;
  logic            dma_start_i;
  logic [AW-1:0]   dma_src_i;
  logic [AW-1:0]   dma_dst_i;
  logic [15:0]     dma_len_i;
  logic            dma_busy_o;
  logic            dma_done_o;
  logic            dma_err_o;
  wb_master_e      gnt_o;

  logic [DW-1:0]   shadow [DEPTH];  // Reference memory.
  logic [31:0]     rng;             // Xorshift state.
  int              n_checks = 0;
  int              n_errs   = 0;
  int              req_cnt  = 0;    // Host requests issued.
  int              resp_cnt = 0;    // Host acks and errs seen.
  int              cycle_cnt = 0;

  wb_mem_sys #(.AW(AW), .DW(DW), .DEPTH(DEPTH)) uut (
    .wb_clk_i    (wb_clk_i),    .wb_rst_i   (wb_rst_i),
    .wb_h_cyc_i  (wb_h_cyc_i),  .wb_h_stb_i (wb_h_stb_i), .wb_h_we_i  (wb_h_we_i),
    .wb_h_adr_i  (wb_h_adr_i),  .wb_h_sel_i (wb_h_sel_i), .wb_h_dat_i (wb_h_dat_i),
    .wb_h_dat_o  (wb_h_dat_o),  .wb_h_ack_o (wb_h_ack_o), .wb_h_err_o (wb_h_err_o),
    .dma_start_i (dma_start_i), .dma_src_i  (dma_src_i),  .dma_dst_i  (dma_dst_i),
    .dma_len_i   (dma_len_i),   .dma_busy_o (dma_busy_o), .dma_done_o (dma_done_o),
    .dma_err_o   (dma_err_o),   .gnt_o      (gnt_o)
  );

  always #10 wb_clk_i = ~wb_clk_i;  // 20 ns period.

  // Watchdog on the whole run.
  always @(posedge wb_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYC) begin
      $display("Timeout: run not finished after %0d cycles, %0d errors so far",
               TIMEOUT_CYC, n_errs);
      $display("Done: errors found");
      $finish;
    end
  end

  // Responses last one cycle, so one count per negedge.
  always @(negedge wb_clk_i) begin
    if (wb_h_ack_o || wb_h_err_o) resp_cnt++;
  end

  // ======================================================================
  // Helpers and compare tasks
  // ======================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [AW-1:0] word_adr(input logic [IW-1:0] idx);
    return AW'(idx) << OB;  // Word index to byte address.
  endfunction

  function automatic logic [IW-1:0] word_idx(input logic [AW-1:0] adr);
    return adr[OB +: IW];
  endfunction

  function automatic logic out_of_range(input logic [AW-1:0] adr);
    return adr >= AW'(DEPTH * NB);  // Past the last RAM byte.
  endfunction

  task automatic check_word(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic match_gnt(input string name, input wb_master_e got, input wb_master_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("FAIL %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic match_count(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errs++;
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // Byte-select rule on the reference memory.
  task automatic shadow_write(input logic [IW-1:0] idx, input logic [NB-1:0] sel,
                              input logic [DW-1:0] dat);
    for (int b = 0; b < NB; b++) begin
      if (sel[b]) shadow[idx][8*b +: 8] = dat[8*b +: 8];
    end
  endtask

  // ======================================================================
  // Host bus and copy control
  // ======================================================================

  // Called at posedge + 2 ns, returns there after one idle cycle.
  task automatic host_access(input logic we, input logic [AW-1:0] adr,
                             input logic [NB-1:0] sel, input logic [DW-1:0] wdat,
                             output logic [DW-1:0] rdat, output logic ack,
                             output logic err, output int lat);
    wb_h_cyc_i = 1'b1;
    wb_h_stb_i = 1'b1;
    wb_h_we_i  = we;
    wb_h_adr_i = adr;
    wb_h_sel_i = sel;
    wb_h_dat_i = wdat;
    req_cnt++;
    lat = 0;
    do begin
      @(negedge wb_clk_i);
      lat++;
    end while (!wb_h_ack_o && !wb_h_err_o);
    ack  = wb_h_ack_o;
    err  = wb_h_err_o;
    rdat = wb_h_dat_o;       // Valid with ack.
    @(posedge wb_clk_i);     // Response taken here.
    #2;
    wb_h_cyc_i = 1'b0;
    wb_h_stb_i = 1'b0;
    wb_h_we_i  = 1'b0;
    @(posedge wb_clk_i);
    #2;
  endtask

  task automatic host_write(input logic [AW-1:0] adr, input logic [NB-1:0] sel,
                            input logic [DW-1:0] dat, output int lat);
    logic [DW-1:0] rdat;
    logic          ack;
    logic          err;
    logic          bad;
    bad = out_of_range(adr);
    host_access(1'b1, adr, sel, dat, rdat, ack, err, lat);
    check_bit("wb_h_ack_o", ack, !bad);
    check_bit("wb_h_err_o", err, bad);
    if (!bad) shadow_write(word_idx(adr), sel, dat); // Bad writes leave memory alone.
  endtask

  task automatic host_read(input logic [AW-1:0] adr, output int lat);
    logic [DW-1:0] rdat;
    logic          ack;
    logic          err;
    logic          bad;
    bad = out_of_range(adr);
    host_access(1'b0, adr, '1, '0, rdat, ack, err, lat);
    check_bit("wb_h_ack_o", ack, !bad);
    check_bit("wb_h_err_o", err, bad);
    if (!bad) check_word("wb_h_dat_o", rdat, shadow[word_idx(adr)]);
  endtask

  // Regions must not overlap; the reference copies once done is seen.
  task automatic run_copy(input int src, input int dst, input int len);
    dma_src_i   = word_adr(IW'(src));
    dma_dst_i   = word_adr(IW'(dst));
    dma_len_i   = 16'(len);
    dma_start_i = 1'b1;
    @(posedge wb_clk_i);
    #2;
    dma_start_i = 1'b0;       // One-cycle pulse.
    do begin
      @(negedge wb_clk_i);
    end while (!dma_done_o);
    check_bit("dma_err_o", dma_err_o, 1'b0);
    for (int i = 0; i < len; i++) begin
      shadow[IW'(dst + i)] = shadow[IW'(src + i)];
    end
    @(posedge wb_clk_i);
    #2;
  endtask

  // ======================================================================
  // Tests
  // ======================================================================

  task automatic reset_state();
    $display("Test 1: values after reset");
    @(negedge wb_clk_i);
    check_bit("wb_h_ack_o", wb_h_ack_o, 1'b0);
    check_bit("wb_h_err_o", wb_h_err_o, 1'b0);
    check_bit("dma_busy_o", dma_busy_o, 1'b0);
    check_bit("dma_done_o", dma_done_o, 1'b0);
    match_gnt("gnt_o", gnt_o, MST_HOST);
    @(posedge wb_clk_i);
    #2;
  endtask

  task automatic host_rw_sweep();
    logic [IW-1:0] idx [N_RW];
    logic [NB-1:0] sel;
    int            lat;
    $display("Test 2: host writes and reads");
    for (int i = 0; i < N_RW; i++) begin
      rng    = xorshift32(rng);
      idx[i] = IW'(rng % 64);                  // Lower region only.
      rng    = xorshift32(rng);
      host_write(word_adr(idx[i]), '1, DW'(rng), lat);
      match_count("host write latency", lat, IDLE_LAT);
    end
    for (int i = 0; i < N_RW; i++) begin
      rng = xorshift32(rng);
      sel = rng[NB-1:0];
      if (sel == '0) sel = NB'(1);              // Empty write trips the RAM check.
      rng = xorshift32(rng);
      host_write(word_adr(idx[i]), sel, DW'(rng), lat);
      match_count("host write latency", lat, IDLE_LAT);
    end
    for (int i = 0; i < N_RW; i++) begin
      host_read(word_adr(idx[i]), lat);
      match_count("host read latency", lat, IDLE_LAT);
    end
  endtask

  task automatic addr_range_errors();
    logic [AW-1:0] bad_adr;
    int            lat;
    $display("Test 3: out-of-range addresses");
    bad_adr = word_adr(IW'(ALIAS)) | AW'(DEPTH * NB); // Alias plus first high bit.
    rng = xorshift32(rng);
    host_write(word_adr(IW'(ALIAS)), '1, DW'(rng), lat);
    rng = xorshift32(rng);
    host_write(bad_adr, '1, DW'(rng), lat);
    match_count("host err latency", lat, IDLE_LAT);
    host_read(bad_adr, lat);
    match_count("host err latency", lat, IDLE_LAT);
    host_read(word_adr(IW'(ALIAS)), lat);       // Still the first value.
  endtask

  task automatic block_copy();
    int lat;
    $display("Test 4: block copy");
    // Fill both copy sources.
    for (int i = 0; i < N_CP + N_CP2; i++) begin
      rng = xorshift32(rng);
      host_write(word_adr(IW'(SRC1 + i)), '1, DW'(rng), lat);
    end
    run_copy(SRC1, DST1, N_CP);
    for (int i = 0; i < N_CP; i++) begin
      host_read(word_adr(IW'(DST1 + i)), lat);
    end
  endtask

  task automatic copy_under_traffic();
    int lat;
    $display("Test 5: host traffic during a copy");
    fork
      run_copy(SRC2, DST2, N_CP2);
      begin
        repeat (2) @(negedge wb_clk_i);
        check_bit("dma_busy_o", dma_busy_o, 1'b1); // Copy under way.
        @(posedge wb_clk_i);
        #2;
        for (int i = 0; i < N_BG; i++) begin
          rng = xorshift32(rng);
          host_write(word_adr(IW'(BG + i)), '1, DW'(rng), lat);
          host_read(word_adr(IW'(BG + i)), lat);
        end
      end
    join
    for (int i = 0; i < N_CP2; i++) begin
      host_read(word_adr(IW'(DST2 + i)), lat);
    end
    match_count("host responses", resp_cnt, req_cnt); // One per request.
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    wb_clk_i    = 1'b0;
    wb_rst_i    = 1'b1;
    wb_h_cyc_i  = 1'b0;
    wb_h_stb_i  = 1'b0;
    wb_h_we_i   = 1'b0;
    wb_h_adr_i  = '0;
    wb_h_sel_i  = '0;
    wb_h_dat_i  = '0;
    dma_start_i = 1'b0;
    dma_src_i   = '0;
    dma_dst_i   = '0;
    dma_len_i   = '0;
    rng         = 32'h1f03_9236;
    repeat (5) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;

    reset_state();
    host_rw_sweep();
    addr_range_errors();
    block_copy();
    copy_under_traffic();

    $display("Summary: %0d checks, %0d errors, %0d host requests",
             n_checks, n_errs, req_cnt);
    if (n_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hdl/selen_wb_pkg.sv
hdl/sram_sp_be.sv
hdl/wb_ram.sv
hdl/wb_arbiter.sv
hdl/wb_blk_copy.sv
hdl/wb_mem_sys.sv
dv/tb_wb_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_wb_mem_sys -o tb_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  echo "run.sh: PASS"
  exit 0
fi
echo "run.sh: FAIL"
exit 1
